//--- logic/pipePkg.sv
package pipePkg;

	// ********************************************************************
	// width types
	// ********************************************************************

	typedef logic [31:0] addrT;
	typedef logic [31:0] wordT;
	typedef logic [4:0]  regIdxT;
	typedef logic [4:0]  excCodeT;
	typedef logic [3:0]  byteStrobeT;
	typedef logic [2:0]  memSizeT;
	typedef logic [4:0]  aluOpT;

	// next-pc source select.
	typedef enum logic [1:0] {
		npcSeq,
		npcBranch,
		npcJump,
		npcReturn
	} npcOpT;

	// writeback result select.
	typedef enum logic [2:0] {
		resAlu,
		resMem,
		resPc8,
		resHiLo,
		resCp0
	} resultSelT;

	// ********************************************************************
	// stage records
	// ********************************************************************

	typedef struct packed {
		addrT       retAddr;
		npcOpT      npcOp;
		addrT       pcOp00;
		addrT       pcOp01;
		addrT       pcOp10;
		logic [3:0] flushCond;
		logic       excEntry;
		addrT       excPc;
	} npcRecT;

	typedef struct packed {
		addrT    pc;
		addrT    ppc;
		logic    exception;
		excCodeT excCode;
	} fetchRecT;

	typedef struct packed {
		addrT    pc;
		wordT    instr;
		logic    exception;
		excCodeT excCode;
	} decodeRecT;

	typedef struct packed {
		addrT      pc;
		aluOpT     aluOp;
		wordT      srcA;
		wordT      srcB;
		wordT      imm;
		regIdxT    rs;
		regIdxT    rt;
		regIdxT    rd;
		logic      regWrite;
		logic      memRead;
		logic      memWrite;
		memSizeT   memSize;
		resultSelT resultSel;
		logic      exception;
		excCodeT   excCode;
		logic      delaySlot;
	} execCtlT;

	typedef struct packed {
		addrT      pc;
		wordT      aluResult;
		wordT      storeData;
		regIdxT    rd;
		logic      regWrite;
		logic      memRead;
		logic      memWrite;
		memSizeT   memSize;
		resultSelT resultSel;
		logic      exception;
		excCodeT   excCode;
	} mem1RecT;

	// added by address translation in memory 1.
	typedef struct packed {
		addrT       paddr;
		byteStrobeT byteStrobe;
		wordT       fwdResult;
	} mem2NewT;

	typedef struct packed {
		addrT       pc;
		wordT       aluResult;
		regIdxT     rd;
		logic       regWrite;
		logic       memRead;
		logic       memWrite;
		memSizeT    memSize;
		resultSelT  resultSel;
		logic       exception;
		excCodeT    excCode;
		addrT       paddr;
		byteStrobeT byteStrobe;
		wordT       fwdResult;
	} mem2RecT;

	typedef struct packed {
		addrT      pc;
		wordT      result;
		wordT      loadData;
		resultSelT resultSel;
		regIdxT    rd;
		logic      regWrite;
	} wbRecT;

	// ********************************************************************
	// reset values
	// ********************************************************************

	localparam addrT bootVector = 32'hBFC0_0000;
	localparam addrT fetchResetPc = bootVector - 32'd4;
	// bit 0 is condition 00, the sequential pick.
	localparam logic [3:0] npcResetFlushCond = 4'b0001;

	localparam npcRecT npcResetVal = '{
		npcOp: npcSeq,
		pcOp00: bootVector,
		flushCond: npcResetFlushCond,
		default: '0
	};

	localparam fetchRecT fetchResetVal = '{
		pc: fetchResetPc,
		default: '0
	};

endpackage

//--- logic/fetchStageRegs.sv
`timescale 1ns/1ps

module fetchStageRegs (
	input  logic             clk,
	input  logic             rstN,

	input  logic             npcWr,
	input  logic             npcFlush,
	input  pipePkg::npcRecT  npcIn,

	input  logic             fetchWr,
	input  logic             fetchFlush,
	input  pipePkg::fetchRecT fetchIn,

	output pipePkg::npcRecT  npcOut,
	output pipePkg::fetchRecT fetchOut
);

	import pipePkg::*;

	// ********************************************************************
	// next-pc record
	// ********************************************************************

	// condition 00 with the boot vector as first candidate.
	always_ff @(posedge clk) begin
		if (!rstN || npcFlush) begin
			npcOut <= npcResetVal;
		end else if (npcWr) begin
			npcOut <= npcIn;
		end
	end

	// ********************************************************************
	// pre-fetch to fetch
	// ********************************************************************

	// sits one word below boot so sequential fetch lands on it.
	always_ff @(posedge clk) begin
		if (!rstN || fetchFlush) begin
			fetchOut <= fetchResetVal;
		end else if (fetchWr) begin
			fetchOut <= fetchIn;
		end
	end

	// the npc mux must see a single select after a restart.
	npcCondOneHot: assert property (
		@(posedge clk) (!rstN || npcFlush) |=> $onehot(npcOut.flushCond)
	) else $error("npcOut flushCond not one-hot after reset or flush");

endmodule

//--- logic/decodeStageReg.sv
`timescale 1ns/1ps

module decodeStageReg (
	input  logic               clk,
	input  logic               rstN,
	input  logic               decodeWr,
	input  logic               decodeFlush,
	input  pipePkg::decodeRecT decodeIn,
	output pipePkg::decodeRecT decodeOut
);

	import pipePkg::*;

	// fetch to decode.
	// pc survives a flush so a later exception still sees a valid epc.
	always_ff @(posedge clk) begin
		if (!rstN || decodeFlush) begin
			decodeOut <= '{
				pc: decodeOut.pc,
				default: '0
			};
		end else if (decodeWr) begin
			decodeOut <= decodeIn;
		end
	end

endmodule

//--- logic/executeStageReg.sv
`timescale 1ns/1ps

module executeStageReg (
	input  logic             clk,
	input  logic             rstN,
	input  logic             execWr,
	input  logic             execFlush,
	input  pipePkg::execCtlT execIn,
	output pipePkg::execCtlT execOut,
	output logic             execStall
);

	import pipePkg::*;

	// ********************************************************************
	// decode to execute
	// ********************************************************************

	always_ff @(posedge clk) begin
		if (!rstN || execFlush) begin
			execOut <= '{
				pc: execOut.pc,
				resultSel: resAlu,
				default: '0
			};
		end else if (execWr) begin
			execOut <= execIn;
		end
	end

	// set while the hazard unit holds this stage.
	// execute uses it to know the same instruction is replayed.
	always_ff @(posedge clk) begin
		if (!rstN || execFlush) begin
			execStall <= 1'b0;
		end else if (execWr) begin
			execStall <= 1'b0;
		end else begin
			execStall <= 1'b1;
		end
	end

	// a repeated instruction sees the same control and operands.
	execStallHolds: assert property (
		@(posedge clk) disable iff (!rstN) execStall |-> $stable(execOut)
	) else $error("execOut changed while execStall was set");

endmodule

//--- logic/memoryStageRegs.sv
`timescale 1ns/1ps

module memoryStageRegs (
	input  logic             clk,
	input  logic             rstN,

	input  logic             mem1Wr,
	input  logic             mem1Flush,
	input  pipePkg::mem1RecT mem1In,

	input  logic             mem2Wr,
	input  logic             mem2Flush,
	input  pipePkg::mem2NewT mem2New,

	output pipePkg::mem1RecT mem1Out,
	output pipePkg::mem2RecT mem2Out
);

	import pipePkg::*;

	mem2RecT mem2In;

	// ********************************************************************
	// execute to memory 1
	// ********************************************************************

	always_ff @(posedge clk) begin
		if (!rstN || mem1Flush) begin
			mem1Out <= '{
				pc: mem1Out.pc,
				resultSel: resAlu,
				default: '0
			};
		end else if (mem1Wr) begin
			mem1Out <= mem1In;
		end
	end

	// memory 2 takes control straight from memory 1.
	// store data was consumed by the data cache request.
	always_comb begin
		mem2In.pc         = mem1Out.pc;
		mem2In.aluResult  = mem1Out.aluResult;
		mem2In.rd         = mem1Out.rd;
		mem2In.regWrite   = mem1Out.regWrite;
		mem2In.memRead    = mem1Out.memRead;
		mem2In.memWrite   = mem1Out.memWrite;
		mem2In.memSize    = mem1Out.memSize;
		mem2In.resultSel  = mem1Out.resultSel;
		mem2In.exception  = mem1Out.exception;
		mem2In.excCode    = mem1Out.excCode;
		mem2In.paddr      = mem2New.paddr;
		mem2In.byteStrobe = mem2New.byteStrobe;
		mem2In.fwdResult  = mem2New.fwdResult;
	end

	// ********************************************************************
	// memory 1 to memory 2
	// ********************************************************************

	always_ff @(posedge clk) begin
		if (!rstN || mem2Flush) begin
			mem2Out <= '{
				pc: mem2Out.pc,
				resultSel: resAlu,
				default: '0
			};
		end else if (mem2Wr) begin
			mem2Out <= mem2In;
		end
	end

	// a store reaching memory 2 must carry lanes to write.
	mem2StoreStrobe: assert property (
		@(posedge clk) disable iff (!rstN) mem2Out.memWrite |-> (mem2Out.byteStrobe != '0)
	) else $error("store in memory 2 with empty byte strobe");

endmodule

//--- logic/writebackStageReg.sv
`timescale 1ns/1ps

module writebackStageReg (
	input  logic           clk,
	input  logic           rstN,
	input  logic           wbWr,
	input  logic           wbFlush,
	input  pipePkg::wbRecT wbIn,
	output pipePkg::wbRecT wbOut
);

	import pipePkg::*;

	// last stop before the register file.
	// regWrite drops on flush so nothing is written back.
	always_ff @(posedge clk) begin
		if (!rstN || wbFlush) begin
			wbOut <= '{
				pc: wbOut.pc,
				resultSel: resAlu,
				default: '0
			};
		end else if (wbWr) begin
			wbOut <= wbIn;
		end
	end

endmodule

//--- logic/cpuPipeRegs.sv
`timescale 1ns/1ps

module cpuPipeRegs (
	input  logic               clk,
	input  logic               rstN,

	// hazard unit strobes.
	input  logic               npcWr,
	input  logic               npcFlush,
	input  logic               fetchWr,
	input  logic               fetchFlush,
	input  logic               decodeWr,
	input  logic               decodeFlush,
	input  logic               execWr,
	input  logic               execFlush,
	input  logic               mem1Wr,
	input  logic               mem1Flush,
	input  logic               mem2Wr,
	input  logic               mem2Flush,
	input  logic               wbWr,
	input  logic               wbFlush,

	// datapath records in.
	input  pipePkg::npcRecT    npcIn,
	input  pipePkg::fetchRecT  fetchIn,
	input  pipePkg::decodeRecT decodeIn,
	input  pipePkg::execCtlT   execIn,
	input  pipePkg::mem1RecT   mem1In,
	input  pipePkg::mem2NewT   mem2New,
	input  pipePkg::wbRecT     wbIn,

	// registered records out.
	output pipePkg::npcRecT    npcOut,
	output pipePkg::fetchRecT  fetchOut,
	output pipePkg::decodeRecT decodeOut,
	output pipePkg::execCtlT   execOut,
	output logic               execStall,
	output pipePkg::mem1RecT   mem1Out,
	output pipePkg::mem2RecT   mem2Out,
	output pipePkg::wbRecT     wbOut
);

	// ********************************************************************
	// stage registers
	// ********************************************************************

	fetchStageRegs uFetch (
		.clk        (clk),
		.rstN       (rstN),
		.npcWr      (npcWr),
		.npcFlush   (npcFlush),
		.npcIn      (npcIn),
		.fetchWr    (fetchWr),
		.fetchFlush (fetchFlush),
		.fetchIn    (fetchIn),
		.npcOut     (npcOut),
		.fetchOut   (fetchOut)
	);

	decodeStageReg uDecode (
		.clk         (clk),
		.rstN        (rstN),
		.decodeWr    (decodeWr),
		.decodeFlush (decodeFlush),
		.decodeIn    (decodeIn),
		.decodeOut   (decodeOut)
	);

	executeStageReg uExecute (
		.clk       (clk),
		.rstN      (rstN),
		.execWr    (execWr),
		.execFlush (execFlush),
		.execIn    (execIn),
		.execOut   (execOut),
		.execStall (execStall)
	);

	// memory 1 and memory 2 share one module.
	memoryStageRegs uMemory (
		.clk       (clk),
		.rstN      (rstN),
		.mem1Wr    (mem1Wr),
		.mem1Flush (mem1Flush),
		.mem1In    (mem1In),
		.mem2Wr    (mem2Wr),
		.mem2Flush (mem2Flush),
		.mem2New   (mem2New),
		.mem1Out   (mem1Out),
		.mem2Out   (mem2Out)
	);

	writebackStageReg uWriteback (
		.clk     (clk),
		.rstN    (rstN),
		.wbWr    (wbWr),
		.wbFlush (wbFlush),
		.wbIn    (wbIn),
		.wbOut   (wbOut)
	);

endmodule

//--- testbench/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstN
);

	// 40 ns period.
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// held low over the first two rising edges.
	initial begin
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rstN = 1'b1;
	end

endmodule

//--- testbench/cpuPipeRegsTb.sv
`timescale 1ns/1ps

module cpuPipeRegsTb;

	import pipePkg::*;

	localparam npcRecT npcBoot = '{
		npcOp: npcSeq,
		pcOp00: 32'hBFC0_0000,
		flushCond: 4'b0001,
		default: '0
	};
	localparam fetchRecT fetchBoot = '{pc: 32'hBFBF_FFFC, default: '0};
	localparam int mem1W = $bits(mem1RecT);

	logic clk;
	logic rstN;
	logic npcWr, npcFlush, fetchWr, fetchFlush, decodeWr, decodeFlush;
	logic execWr, execFlush, mem1Wr, mem1Flush, mem2Wr, mem2Flush, wbWr, wbFlush;
	npcRecT npcIn, npcOut;
	fetchRecT fetchIn, fetchOut;
	decodeRecT decodeIn, decodeOut;
	execCtlT execIn, execOut;
	logic execStall;
	mem1RecT mem1In, mem1Out;
	mem2NewT mem2New;
	mem2RecT mem2Out;
	wbRecT wbIn, wbOut;

	// reference model state.
	npcRecT expNpc;
	fetchRecT expFetch;
	decodeRecT expDecode, decodeSeen;
	execCtlT expExec, execSeen;
	logic expStall;
	mem1RecT expMem1, mem1Seen;
	mem2RecT expMem2, mem2Seen;
	wbRecT expWb, wbSeen;
	logic started = 1'b0;
	logic decPcKnown = 1'b0;
	logic execPcKnown = 1'b0;
	logic mem1PcKnown = 1'b0;
	logic mem2PcKnown = 1'b0;
	logic wbPcKnown = 1'b0;
	logic [15:0] lfsrState = 16'd58846;

	tbClock clockGen (.clk(clk), .rstN(rstN));

	cpuPipeRegs UUT (.*);

	// ********************************************************************
	// reference model
	// ********************************************************************

	always @(posedge clk) begin
		if (!rstN) started <= 1'b1;
		if (!rstN || npcFlush) expNpc <= npcBoot;
		else if (npcWr) expNpc <= npcIn;
		if (!rstN || fetchFlush) expFetch <= fetchBoot;
		else if (fetchWr) expFetch <= fetchIn;
		if (!rstN || decodeFlush) begin
			expDecode <= '{pc: expDecode.pc, default: '0};
		end else if (decodeWr) begin
			expDecode <= decodeIn;
			decPcKnown <= 1'b1;
		end
		if (!rstN || execFlush) begin
			expExec <= '{pc: expExec.pc, resultSel: resAlu, default: '0};
			expStall <= 1'b0;
		end else begin
			expStall <= !execWr;
			if (execWr) expExec <= execIn;
			if (execWr) execPcKnown <= 1'b1;
		end
		if (!rstN || mem1Flush) begin
			expMem1 <= '{pc: expMem1.pc, resultSel: resAlu, default: '0};
		end else if (mem1Wr) begin
			expMem1 <= mem1In;
			mem1PcKnown <= 1'b1;
		end
		// memory 2 is memory 1 less store data, plus the translated fields.
		if (!rstN || mem2Flush) begin
			expMem2 <= '{pc: expMem2.pc, resultSel: resAlu, default: '0};
		end else if (mem2Wr) begin
			expMem2 <= {expMem1.pc, expMem1.aluResult, expMem1[mem1W-97:0], mem2New};
			mem2PcKnown <= mem1PcKnown;
		end
		if (!rstN || wbFlush) begin
			expWb <= '{pc: expWb.pc, resultSel: resAlu, default: '0};
		end else if (wbWr) begin
			expWb <= wbIn;
			wbPcKnown <= 1'b1;
		end
	end

	// pc is undefined until the first write.
	always_comb begin
		decodeSeen = decodeOut;
		execSeen = execOut;
		mem1Seen = mem1Out;
		mem2Seen = mem2Out;
		wbSeen = wbOut;
		if (!decPcKnown) decodeSeen.pc = expDecode.pc;
		if (!execPcKnown) execSeen.pc = expExec.pc;
		if (!mem1PcKnown) mem1Seen.pc = expMem1.pc;
		if (!mem2PcKnown) mem2Seen.pc = expMem2.pc;
		if (!wbPcKnown) wbSeen.pc = expWb.pc;
	end

	// ********************************************************************
	// checks
	// ********************************************************************

	task automatic reportMismatch(input string name, input logic [255:0] expVal,
			input logic [255:0] actVal);
		$display("TEST FAILED");
		$display("Error: %s expected %0h actual %0h", name, expVal, actVal);
		$fatal(1, "%s output does not match", name);
	endtask

	npcMatch: assert property (@(posedge clk) started |-> npcOut == expNpc)
		else reportMismatch("npc", 256'($sampled(expNpc)), 256'($sampled(npcOut)));
	fetchMatch: assert property (@(posedge clk) started |-> fetchOut == expFetch)
		else reportMismatch("fetch", 256'($sampled(expFetch)), 256'($sampled(fetchOut)));
	decodeMatch: assert property (@(posedge clk) started |-> decodeSeen == expDecode)
		else reportMismatch("decode", 256'($sampled(expDecode)), 256'($sampled(decodeSeen)));
	execMatch: assert property (@(posedge clk) started |-> execSeen == expExec)
		else reportMismatch("execute", 256'($sampled(expExec)), 256'($sampled(execSeen)));
	stallMatch: assert property (@(posedge clk) started |-> execStall == expStall)
		else reportMismatch("execStall", 256'($sampled(expStall)), 256'($sampled(execStall)));
	mem1Match: assert property (@(posedge clk) started |-> mem1Seen == expMem1)
		else reportMismatch("memory1", 256'($sampled(expMem1)), 256'($sampled(mem1Seen)));
	mem2Match: assert property (@(posedge clk) started |-> mem2Seen == expMem2)
		else reportMismatch("memory2", 256'($sampled(expMem2)), 256'($sampled(mem2Seen)));
	wbMatch: assert property (@(posedge clk) started |-> wbSeen == expWb)
		else reportMismatch("writeback", 256'($sampled(expWb)), 256'($sampled(wbSeen)));

	// ********************************************************************
	// stimulus
	// ********************************************************************

	// galois lfsr, one step per bit.
	task automatic takeBits(input int n, output logic [255:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 16'hB400) : (lfsrState >> 1);
			v[i] = lfsrState[0];
		end
	endtask

	task automatic randomizeRecords();
		logic [255:0] v;
		takeBits($bits(npcRecT), v);
		npcIn = v[$bits(npcRecT)-1:0];
		takeBits($bits(fetchRecT), v);
		fetchIn = v[$bits(fetchRecT)-1:0];
		takeBits($bits(decodeRecT), v);
		decodeIn = v[$bits(decodeRecT)-1:0];
		takeBits($bits(execCtlT), v);
		execIn = v[$bits(execCtlT)-1:0];
		takeBits($bits(mem1RecT), v);
		mem1In = v[$bits(mem1RecT)-1:0];
		takeBits($bits(mem2NewT), v);
		mem2New = v[$bits(mem2NewT)-1:0];
		// stores need at least one lane.
		if (mem2New.byteStrobe == '0) mem2New.byteStrobe = 4'b0001;
		takeBits($bits(wbRecT), v);
		wbIn = v[$bits(wbRecT)-1:0];
	endtask

	task automatic setEnables(input logic [6:0] wr, input logic [6:0] fl);
		{npcWr, fetchWr, decodeWr, execWr, mem1Wr, mem2Wr, wbWr} = wr;
		{npcFlush, fetchFlush, decodeFlush, execFlush, mem1Flush, mem2Flush, wbFlush} = fl;
	endtask

	task automatic step();
		@(posedge clk);
		#2;
	endtask

	// flush comes up about one time in eight.
	task automatic driveMixed();
		logic [255:0] v;
		logic [6:0] fl;
		takeBits(28, v);
		for (int i = 0; i < 7; i++) fl[i] = &v[7 + 3 * i +: 3];
		randomizeRecords();
		setEnables(v[6:0], fl);
		step();
	endtask

	task automatic waitReset();
		int cycles;
		cycles = 0;
		while (rstN !== 1'b1 && cycles < 10) begin
			@(posedge clk);
			cycles++;
		end
		if (rstN !== 1'b1) begin
			$display("TEST FAILED");
			$fatal(1, "reset was never released");
		end
	endtask

	initial begin
		npcIn = '0;
		fetchIn = '0;
		decodeIn = '0;
		execIn = '0;
		mem1In = '0;
		mem2New = '0;
		wbIn = '0;
		setEnables('0, '0);
		waitReset();
		#2;
		repeat (20) begin
			randomizeRecords();
			setEnables('1, '0);
			step();
		end
		repeat (3) begin
			randomizeRecords();
			setEnables('0, '0);
			step();
		end
		randomizeRecords();
		setEnables('1, '1);
		step();
		repeat (80) driveMixed();
		setEnables('0, '0);
		step();
		step();
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- sources.f
logic/pipePkg.sv
logic/fetchStageRegs.sv
logic/decodeStageReg.sv
logic/executeStageReg.sv
logic/memoryStageRegs.sv
logic/writebackStageReg.sv
logic/cpuPipeRegs.sv
testbench/tbClock.sv
testbench/cpuPipeRegsTb.sv

//--- Makefile
TOP = cpuPipeRegsTb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): sources.f logic/*.sv testbench/*.sv
	verilator --binary --timing --assert -f sources.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f sources.f --top-module cpuPipeRegs

clean:
	rm -rf obj_dir
